//--- filelist.f
+incdir+bench
common/fpu_pkg.sv
common/shift_if.sv
logic/round_unit.sv
i2f/norm_shifter.sv
i2f/i2f_ctrl.sv
logic/fpu_i2f_top.sv
bench/tb_fpu_i2f.sv

//--- Makefile
# Verilator build and run for the integer-to-float converter testbench

VERILATOR ?= verilator
TOP       ?= tb_fpu_i2f
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0

BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := bench/i2f_model.svh

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/i2f_model.svh
// reference integer-to-single conversion
// ieee rounding to 24 significant bits, inexact set when the rounder increments
`ifndef I2F_MODEL_SVH
`define I2F_MODEL_SVH

function automatic void model_convert(
    input  logic        sgn,
    input  logic [31:0] mag,
    input  logic [2:0]  rm,
    output logic [31:0] word,
    output logic        inexact,
    output logic        carry,
    output int          lead
);
    int          sh;
    logic [31:0] keep;   // 24 kept bits, hidden one on top
    logic [31:0] rem;    // dropped bits
    logic [31:0] half;   // weight of the first dropped bit
    logic        inc;
    logic [7:0]  expo;
    lead = -1;
    for (int i = 0; i < 32; i++) begin
        if (mag[i]) lead = i;              // highest set bit wins
    end
    word    = '0;
    inexact = 1'b0;
    carry   = 1'b0;
    if (lead < 0) return;                  // zero maps to +0
    if (lead <= 23) begin
        keep = mag << (23 - lead);         // exact, nothing dropped
        rem  = '0;
        half = '0;
    end else begin
        sh   = lead - 23;
        keep = mag >> sh;
        rem  = mag & ((32'd1 << sh) - 32'd1);
        half = 32'd1 << (sh - 1);
    end
    case (rm)
        3'b000:  inc = (half != 0) && ((rem > half) || ((rem == half) && keep[0]));
        3'b100:  inc = (half != 0) && (rem >= half);
        3'b011:  inc = !sgn && (rem != 0);
        3'b010:  inc = sgn && (rem != 0);
        default: inc = 1'b0;
    endcase
    keep = keep + 32'(inc);
    if (keep[24]) begin                    // carry past the hidden one
        carry = 1'b1;
        keep  = keep >> 1;
        lead  = lead + 1;
    end
    expo    = 8'(127 + lead);
    word    = {sgn, expo, keep[22:0]};
    inexact = inc;
endfunction

`endif

//--- bench/tb_fpu_i2f.sv
// tb_fpu_i2f
// testbench for the integer-to-float converter. drives four-phase
// handshakes, compares against the reference model and checks latency
// and protocol with assertions
`include "i2f_model.svh"

module tb_fpu_i2f;

    // transactions per stimulus group, in the order below
    localparam int N_TX = 16 + 240 + 20 + 200 + 20 + 3;

    logic        clk_i;
    logic        rstn_i;
    logic        req_i;
    logic        sign_i;
    logic [31:0] int_i;
    logic [2:0]  rmode_i;
    logic        ack_o;
    logic [31:0] result_o;
    logic        inexact_o;

    int prot_errs;
    int data_errs;

    fpu_i2f_top #(.INT_WIDTH(32)) u_fpu_i2f_top (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .req_i     (req_i),
        .sign_i    (sign_i),
        .int_i     (int_i),
        .rmode_i   (rmode_i),
        .ack_o     (ack_o),
        .result_o  (result_o),
        .inexact_o (inexact_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // protocol assertions
    // ------------------------------------------------------------------------
    a_rise_needs_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(ack_o) |-> req_i)
        else begin
            prot_errs++;
            $display("** Error at %0t: ack rose without req", $time);
        end

    a_ack_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_o && req_i |=> ack_o)
        else begin
            prot_errs++;
            $display("** Error at %0t: ack dropped while req high", $time);
        end

    a_ack_falls: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $fell(req_i) && ack_o |=> ack_o ##1 !ack_o)
        else begin
            prot_errs++;
            $display("** Error at %0t: ack release timing wrong", $time);
        end

    a_result_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_o && $past(ack_o) |-> $stable(result_o) && $stable(inexact_o))
        else begin
            prot_errs++;
            $display("** Error at %0t: result changed under ack", $time);
        end

    // ------------------------------------------------------------------------
    // one four-phase transaction entered 1 unit after a rising edge
    // ------------------------------------------------------------------------
    task automatic convert(input logic sgn, input logic [31:0] mag, input logic [2:0] rm);
        logic [31:0] exp_word;
        logic        exp_inx;
        logic        carry;
        int          lead;
        int          exp_lat;
        int          edges;
        int          hold;
        model_convert(sgn, mag, rm, exp_word, exp_inx, carry, lead);
        exp_lat = (lead < 0) ? 3 : 4 + lead;             // lead includes the carry bit
        req_i   = 1'b1;
        sign_i  = sgn;
        int_i   = mag;
        rmode_i = rm;
        edges   = 0;
        do begin
            @(posedge clk_i);
            #1;
            edges++;
        end while (!ack_o);
        assert (result_o === exp_word && inexact_o === exp_inx)
            else begin
                data_errs++;
                $display("** Error at %0t: in=%h s=%b rm=%0d got %h/%b exp %h/%b",
                         $time, mag, sgn, rm, result_o, inexact_o, exp_word, exp_inx);
            end
        assert (edges - 1 == exp_lat)
            else begin
                data_errs++;
                $display("** Error at %0t: in=%h latency %0d exp %0d",
                         $time, mag, edges - 1, exp_lat);
            end
        hold = 1 + int'($urandom % 4);                   // req stays up a while under ack
        repeat (hold) @(posedge clk_i);
        #1;
        req_i = 1'b0;                                    // release
        do begin
            @(posedge clk_i);
            #1;
        end while (ack_o);
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] v;
        logic [31:0] keep;
        int          sh;
        prot_errs = 0;
        data_errs = 0;
        void'($urandom(32'hd0fa));
        rstn_i  = 1'b0;
        req_i   = 1'b0;
        sign_i  = 1'b0;
        int_i   = '0;
        rmode_i = '0;
        repeat (5) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        assert (ack_o === 1'b0 && result_o === '0 && inexact_o === 1'b0)
            else begin
                data_errs++;
                $display("** Error at %0t: outputs not idle after reset", $time);
            end

        // zero input under every mode code and both signs
        for (int m = 0; m < 8; m++) begin
            for (int s = 0; s < 2; s++) convert(1'(s), 32'd0, 3'(m));
        end

        // powers of two below 2^24
        for (int p = 0; p < 24; p++) begin
            for (int m = 0; m < 5; m++) begin
                for (int s = 0; s < 2; s++) convert(1'(s), 32'd1 << p, 3'(m));
            end
        end

        // exact random magnitudes
        for (int i = 0; i < 20; i++) begin
            v = $urandom & 32'h00ff_ffff;
            convert(1'(i % 2), v, 3'(i % 5));
        end

        // inexact random magnitudes over all modes and signs
        for (int i = 0; i < 200; i++) begin
            v = $urandom;
            if (v < 32'h0100_0000) v = v | (32'd1 << (24 + ($urandom % 8)));
            convert(1'((i / 5) % 2), v, 3'(i % 5));
        end

        // exact ties with only g set below the lsb
        for (int m = 0; m < 5; m++) begin
            for (int s = 0; s < 2; s++) begin
                for (int l = 0; l < 2; l++) begin
                    keep = 32'h0080_0000 | ($urandom & 32'h007f_fffe) | 32'(l);
                    sh   = 1 + int'($urandom % 8);
                    v    = (keep << sh) | (32'd1 << (sh - 1));
                    convert(1'(s), v, 3'(m));
                end
            end
        end

        // rounding carry into a new bit
        convert(1'b0, 32'hffff_ffff, 3'b000);
        convert(1'b0, 32'hffff_ffff, 3'b011);
        convert(1'b0, 32'hffff_ffff, 3'b001);

        repeat (4) @(posedge clk_i);
        $display("errors: protocol %0d, data %0d", prot_errs, data_errs);
        if (prot_errs == 0 && data_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog allowing 50 cycles of 4 units per transaction plus reset margin
    initial begin
        #(N_TX * 50 * 4 + 1000);
        $display("timeout: a handshake did not complete in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- logic/fpu_i2f_top.sv
// fpu_i2f_top
// integer-to-single-precision converter with a four-phase req/ack
// handshake. joins controller, normalization shifter and rounder
module fpu_i2f_top #(
    parameter int INT_WIDTH = 32
) (
    input  logic                 clk_i,      // rising edge
    input  logic                 rstn_i,     // async, active low
    input  logic                 req_i,      // start request
    input  logic                 sign_i,     // operand sign
    input  logic [INT_WIDTH-1:0] int_i,      // operand magnitude
    input  fpu_pkg::rmode_t      rmode_i,    // rounding mode
    output logic                 ack_o,      // result valid
    output fpu_pkg::word_t       result_o,   // single word
    output logic                 inexact_o   // rounded result
);

    logic            sign_w;    // captured sign
    fpu_pkg::rmode_t rmode_w;   // captured mode
    logic            hidden_w;
    fpu_pkg::man_t   man_w;
    logic            g_w;
    logic            r_w;
    logic            s_w;
    logic            rnd_en_w;
    fpu_pkg::rnd_t   rnd_w;     // rounded mantissa back to shifter

    shift_if #(.INT_WIDTH(INT_WIDTH)) u_shf ();

    i2f_ctrl #(.INT_WIDTH(INT_WIDTH)) u_i2f_ctrl (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .req_i     (req_i),
        .sign_i    (sign_i),
        .int_i     (int_i),
        .rmode_i   (rmode_i),
        .shf       (u_shf.ctrl),
        .rnd_en_i  (rnd_en_w),
        .hidden_i  (hidden_w),
        .man_i     (man_w),
        .ack_o     (ack_o),
        .result_o  (result_o),
        .inexact_o (inexact_o),
        .sign_o    (sign_w),
        .rmode_o   (rmode_w)
    );

    norm_shifter #(.INT_WIDTH(INT_WIDTH)) u_norm_shifter (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .shf      (u_shf.shifter),
        .rnd_i    (rnd_w),
        .hidden_o (hidden_w),
        .man_o    (man_w),
        .g_o      (g_w),
        .r_o      (r_w),
        .s_o      (s_w)
    );

    round_unit u_round_unit (
        .sign_i   (sign_w),
        .rmode_i  (rmode_w),
        .hidden_i (hidden_w),
        .man_i    (man_w),
        .g_i      (g_w),
        .r_i      (r_w),
        .s_i      (s_w),
        .rnd_en_o (rnd_en_w),
        .rnd_o    (rnd_w)
    );

endmodule

//--- i2f/i2f_ctrl.sv
// i2f_ctrl
// conversion engine for the integer-to-float unit. runs the req/ack
// handshake, steps the shifter through normalize / round / renormalize,
// counts the exponent and builds the result word and inexact flag
module i2f_ctrl #(
    parameter int INT_WIDTH = 32
) (
    input  logic                 clk_i,      // rising edge
    input  logic                 rstn_i,     // async, active low
    input  logic                 req_i,      // four-phase request
    input  logic                 sign_i,     // operand sign
    input  logic [INT_WIDTH-1:0] int_i,      // operand magnitude
    input  fpu_pkg::rmode_t      rmode_i,    // rounding mode
    shift_if.ctrl                shf,        // shift register control
    input  logic                 rnd_en_i,   // rounder increments
    input  logic                 hidden_i,   // shifter hidden bit
    input  fpu_pkg::man_t        man_i,      // shifter mantissa
    output logic                 ack_o,      // four-phase acknowledge
    output fpu_pkg::word_t       result_o,   // single word
    output logic                 inexact_o,  // result was rounded
    output logic                 sign_o,     // captured sign to rounder
    output fpu_pkg::rmode_t      rmode_o     // captured mode to rounder
);

    fpu_pkg::i2f_state_t state_q;
    logic                sign_q;
    fpu_pkg::rmode_t     rmode_q;
    fpu_pkg::exp_t       exp_q;      // exponent counter
    logic                inexact_q;
    logic                pass2_q;    // second normalization pass
    logic                ack_q;
    fpu_pkg::word_t      result_q;
    logic                rnd_carry;  // increment ripples past hidden one

    // carry only when 1.111...1 gets incremented
    assign rnd_carry = rnd_en_i & hidden_i & (&man_i);

    // -------------------------------------------------------------------------
    // shifter commands
    // -------------------------------------------------------------------------
    assign shf.int_val  = int_i;
    assign shf.load     = (state_q == fpu_pkg::LOAD);
    assign shf.load_rnd = (state_q == fpu_pkg::ROUND);

    // first shift already issued during the zero check
    assign shf.shift = ((state_q == fpu_pkg::CHECK_ZERO) && !shf.is_zero && !shf.norm_done)
                     || ((state_q == fpu_pkg::NORMALIZE) && !shf.norm_done);

    // -------------------------------------------------------------------------
    // control engine
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= fpu_pkg::IDLE;
            sign_q    <= 1'b0;
            rmode_q   <= fpu_pkg::RM_RNE;
            exp_q     <= '0;
            inexact_q <= 1'b0;
            pass2_q   <= 1'b0;
            ack_q     <= 1'b0;
            result_q  <= '0;
        end else begin
            // every right shift doubles the scale
            if (shf.shift) begin
                exp_q <= exp_q + fpu_pkg::exp_t'(1);
            end

            case (state_q)
                fpu_pkg::IDLE: begin
                    ack_q <= 1'b0;                       // close previous handshake
                    if (req_i && !ack_q) begin
                        sign_q    <= sign_i;
                        rmode_q   <= rmode_i;
                        exp_q     <= fpu_pkg::EXP_BIAS;  // value 1.0 before shifting
                        inexact_q <= 1'b0;
                        pass2_q   <= 1'b0;
                        state_q   <= fpu_pkg::LOAD;
                    end
                end

                fpu_pkg::LOAD: begin
                    state_q <= fpu_pkg::CHECK_ZERO;      // shifter loads on this edge
                end

                fpu_pkg::CHECK_ZERO: begin
                    if (shf.is_zero) begin
                        state_q <= fpu_pkg::FINALIZE;    // nothing to normalize
                    end else if (shf.norm_done) begin
                        state_q <= fpu_pkg::ROUND;       // operand was 1
                    end else begin
                        state_q <= fpu_pkg::NORMALIZE;
                    end
                end

                fpu_pkg::NORMALIZE: begin
                    if (shf.norm_done) begin
                        state_q <= pass2_q ? fpu_pkg::FINALIZE : fpu_pkg::ROUND;
                    end else if (pass2_q) begin
                        state_q <= fpu_pkg::FINALIZE;    // carry needs a single shift
                    end
                end

                fpu_pkg::ROUND: begin
                    inexact_q <= inexact_q | rnd_en_i;   // sticky
                    if (rnd_carry) begin
                        pass2_q <= 1'b1;
                        state_q <= fpu_pkg::NORMALIZE;
                    end else begin
                        state_q <= fpu_pkg::FINALIZE;
                    end
                end

                fpu_pkg::FINALIZE: begin
                    if (shf.is_zero) begin
                        result_q <= '0;                  // zero is always +0
                    end else begin
                        result_q <= {sign_q, exp_q, man_i};
                    end
                    ack_q   <= 1'b1;
                    state_q <= fpu_pkg::WAIT_REL;
                end

                fpu_pkg::WAIT_REL: begin
                    if (!req_i) begin
                        state_q <= fpu_pkg::IDLE;        // ack drops on the next edge
                    end
                end

                default: begin
                    state_q <= fpu_pkg::IDLE;
                end
            endcase
        end
    end

    assign ack_o     = ack_q;
    assign result_o  = result_q;
    assign inexact_o = inexact_q;
    assign sign_o    = sign_q;
    assign rmode_o   = rmode_q;

    // -------------------------------------------------------------------------
    // checks
    // -------------------------------------------------------------------------
    a_load_shift_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(shf.load && shf.shift));

    // ack held for as long as the caller keeps req up
    a_ack_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_q && req_i |=> ack_q);

endmodule

//--- i2f/norm_shifter.sv
// norm_shifter
// normalization shift register. integer part above the binary point,
// mantissa below it, then guard, round and sticky. shifts right one bit
// per cycle and reports normalized / zero
module norm_shifter #(
    parameter int INT_WIDTH = 32
) (
    input  logic           clk_i,     // rising edge
    input  logic           rstn_i,    // async, active low
    shift_if.shifter       shf,       // commands from controller
    input  fpu_pkg::rnd_t  rnd_i,     // rounder output for reload
    output logic           hidden_o,  // bit left of binary point
    output fpu_pkg::man_t  man_o,     // fraction bits
    output logic           g_o,       // guard
    output logic           r_o,       // round
    output logic           s_o        // sticky
);

    logic [INT_WIDTH-1:0] upper_q;  // integer part
    fpu_pkg::man_t        lower_q;  // fraction part
    logic                 g_q;
    logic                 r_q;
    logic                 s_q;

    // -------------------------------------------------------------------------
    // shift register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            upper_q <= '0;
            lower_q <= '0;
            g_q     <= 1'b0;
            r_q     <= 1'b0;
            s_q     <= 1'b0;
        end else if (shf.load) begin
            upper_q <= shf.int_val;                    // binary point right of bit 0
            lower_q <= '0;
            g_q     <= 1'b0;
            r_q     <= 1'b0;
            s_q     <= 1'b0;
        end else if (shf.load_rnd) begin
            upper_q <= INT_WIDTH'(rnd_i[24:23]);       // carry + hidden one
            lower_q <= rnd_i[22:0];
            g_q     <= 1'b0;                           // extension consumed
            r_q     <= 1'b0;
            s_q     <= 1'b0;
        end else if (shf.shift) begin
            upper_q <= {1'b0, upper_q[INT_WIDTH-1:1]};
            lower_q <= {upper_q[0], lower_q[22:1]};    // integer lsb into fraction
            g_q     <= lower_q[0];
            r_q     <= g_q;
            s_q     <= s_q | r_q;                      // keep any lost one
        end
    end

    // -------------------------------------------------------------------------
    // status, combinational
    // -------------------------------------------------------------------------
    assign shf.norm_done = (upper_q == INT_WIDTH'(1));  // hidden one in place
    assign shf.is_zero   = (upper_q == '0);

    assign hidden_o = upper_q[0];
    assign man_o    = lower_q;
    assign g_o      = g_q;
    assign r_o      = r_q;
    assign s_o      = s_q;

    // controller must stop once the hidden one has arrived
    a_no_overshift: assert property (@(posedge clk_i) disable iff (!rstn_i)
        shf.shift |-> !shf.norm_done);

endmodule

//--- logic/round_unit.sv
// round_unit
// rounding decision from mode, sign and guard/round/sticky, followed by
// the mantissa incrementer. purely combinational
module round_unit (
    input  logic            sign_i,    // result sign
    input  fpu_pkg::rmode_t rmode_i,   // rounding mode
    input  logic            hidden_i,  // hidden one
    input  fpu_pkg::man_t   man_i,     // mantissa before rounding
    input  logic            g_i,       // guard
    input  logic            r_i,       // round
    input  logic            s_i,       // sticky
    output logic            rnd_en_o,  // increment applies
    output fpu_pkg::rnd_t   rnd_o      // carry, hidden one, mantissa
);

    logic any_lost;  // some nonzero bit below the lsb

    assign any_lost = g_i | r_i | s_i;

    // -------------------------------------------------------------------------
    // mode decode
    // -------------------------------------------------------------------------
    always_comb begin
        case (rmode_i)
            fpu_pkg::RM_RNE: begin
                // above half, or exact half with odd lsb
                rnd_en_o = g_i & (r_i | s_i | man_i[0]);
            end
            fpu_pkg::RM_RMM: begin
                rnd_en_o = g_i;              // half or more rounds away
            end
            fpu_pkg::RM_RUP: begin
                rnd_en_o = !sign_i & any_lost;  // positive moves up in magnitude
            end
            fpu_pkg::RM_RDN: begin
                rnd_en_o = sign_i & any_lost;   // negative moves up in magnitude
            end
            default: begin
                rnd_en_o = 1'b0;             // rtz and undefined codes truncate
            end
        endcase
    end

    // -------------------------------------------------------------------------
    // incrementer
    // -------------------------------------------------------------------------
    assign rnd_o = {1'b0, hidden_i, man_i} + fpu_pkg::rnd_t'(rnd_en_o);

endmodule

//--- common/shift_if.sv
// shift_if
// command and status lines between the conversion controller and the
// normalization shift register
interface shift_if #(
    parameter int INT_WIDTH = 32
);

    // controller to shifter
    logic                 load;       // integer into upper part, rest cleared
    logic                 load_rnd;   // take rounder output
    logic                 shift;      // one step right, sticky or-in
    logic [INT_WIDTH-1:0] int_val;    // integer operand

    // shifter to controller
    logic                 norm_done;  // upper part equals one
    logic                 is_zero;    // upper part all zero

    modport ctrl (
        output load,
        output load_rnd,
        output shift,
        output int_val,
        input  norm_done,
        input  is_zero
    );

    modport shifter (
        input  load,
        input  load_rnd,
        input  shift,
        input  int_val,
        output norm_done,
        output is_zero
    );

endinterface

//--- common/fpu_pkg.sv
// fpu_pkg
// shared field types, rounding mode codes and controller states for the
// integer-to-float converter
package fpu_pkg;

    // -------------------------------------------------------------------------
    // ieee single fields
    // -------------------------------------------------------------------------
    typedef logic [31:0] word_t;   // complete single word
    typedef logic [7:0]  exp_t;    // biased exponent
    typedef logic [22:0] man_t;    // stored mantissa, hidden one excluded
    typedef logic [2:0]  rmode_t;  // rounding mode code

    // carry + hidden one + mantissa, as produced by the rounder
    typedef logic [24:0] rnd_t;

    // exponent of 1.0
    localparam exp_t EXP_BIAS = 8'd127;

    // -------------------------------------------------------------------------
    // rounding modes, other codes truncate
    // -------------------------------------------------------------------------
    localparam rmode_t RM_RNE = 3'b000;  // nearest, ties to even
    localparam rmode_t RM_RTZ = 3'b001;  // toward zero
    localparam rmode_t RM_RDN = 3'b010;  // toward -inf
    localparam rmode_t RM_RUP = 3'b011;  // toward +inf
    localparam rmode_t RM_RMM = 3'b100;  // nearest, ties away from zero

    // -------------------------------------------------------------------------
    // conversion controller states
    // -------------------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,        // wait for req
        LOAD,        // integer into shift register
        CHECK_ZERO,  // zero bypass, first shift
        NORMALIZE,   // shift until hidden one at binary point
        ROUND,       // reload from rounder
        FINALIZE,    // assemble result word
        WAIT_REL     // hold ack until req drops
    } i2f_state_t;

endpackage
